// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= jtag_tap_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/jtag_tap_tb.sv ====
`timescale 1ns/1ps
`include "jtag_config.svh"

module jtag_tap_tb;
  import jtag_pkg::*;

  localparam int NUM_SCANS = 13;
  localparam int SCAN_TIMEOUT = 4 * 200 * NUM_SCANS;
  localparam int PAD = 32 - `JTAG_IR_LEN;

  logic                      TCK;
  logic                      por_n;
  logic                      pulse_n;
  logic                      rst_n;
  logic                      TMS;
  logic                      TDI;
  logic                      TDO;
  logic [`JTAG_USER_LEN-1:0] user_data;

  integer                    seed;
  int                        value_errors;
  int                        tdo_errors;
  logic                      last_tms;
  tap_state_e                model_state;
  jtag_instr_e               model_instr;
  logic [`JTAG_USER_LEN-1:0] model_user;

  // power-on reset and the mid-scan pulse share the TRST pin
  assign rst_n = por_n & pulse_n;

  tb_clock_gen u_clock_gen (
    .TCK   (TCK),
    .rst_n (por_n)
  );

  jtag_tap_top u_dut (
    .TCK       (TCK),
    .rst_n     (rst_n),
    .TMS       (TMS),
    .TDI       (TDI),
    .TDO       (TDO),
    .user_data (user_data)
  );

  // TAP state table from the standard
  function automatic tap_state_e tap_next(input tap_state_e s, input logic tms);
    case (s)
      TEST_LOGIC_RESET: return tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
      RUN_TEST_IDLE:    return tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      SELECT_DR_SCAN:   return tms ? SELECT_IR_SCAN : CAPTURE_DR;
      CAPTURE_DR:       return tms ? EXIT1_DR : SHIFT_DR;
      SHIFT_DR:         return tms ? EXIT1_DR : SHIFT_DR;
      EXIT1_DR:         return tms ? UPDATE_DR : PAUSE_DR;
      PAUSE_DR:         return tms ? EXIT2_DR : PAUSE_DR;
      EXIT2_DR:         return tms ? UPDATE_DR : SHIFT_DR;
      UPDATE_DR:        return tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      SELECT_IR_SCAN:   return tms ? TEST_LOGIC_RESET : CAPTURE_IR;
      CAPTURE_IR:       return tms ? EXIT1_IR : SHIFT_IR;
      SHIFT_IR:         return tms ? EXIT1_IR : SHIFT_IR;
      EXIT1_IR:         return tms ? UPDATE_IR : PAUSE_IR;
      PAUSE_IR:         return tms ? EXIT2_IR : PAUSE_IR;
      EXIT2_IR:         return tms ? UPDATE_IR : SHIFT_IR;
      default:          return tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
    endcase
  endfunction

  // unlisted opcodes act as bypass
  function automatic jtag_instr_e decode_opcode(input logic [`JTAG_IR_LEN-1:0] code);
    case (code)
      5'b00001: return INSTR_IDCODE;
      5'b00010: return INSTR_USER_DATA;
      default:  return INSTR_BYPASS;
    endcase
  endfunction

  // expected TDO stream of a 32-bit DR scan
  function automatic logic [31:0] predict_dr(input jtag_instr_e ins,
                                             input logic [`JTAG_USER_LEN-1:0] user,
                                             input logic [31:0] tdi);
    case (ins)
      INSTR_IDCODE:    return `JTAG_IDCODE;
      INSTR_USER_DATA: return user;
      default:         return {tdi[30:0], 1'b0};
    endcase
  endfunction

  // one TCK cycle, TDO sampled mid-cycle where it is stable
  task automatic step(input logic tms, input logic tdi, output logic tdo);
    @(posedge TCK);
    model_state = tap_next(model_state, last_tms);
    last_tms = tms;
    TMS <= tms;
    TDI <= tdi;
    @(negedge TCK);
    tdo = TDO;
    if (model_state != SHIFT_DR && model_state != SHIFT_IR && tdo !== 1'b0)
    begin
      tdo_errors++;
      $display("[FAIL] time %0t: TDO high in state %s", $time, model_state.name());
    end
  endtask

  task automatic move(input logic tms);
    logic d;
    step(tms, 1'b0, d);
  endtask

  // full scan from Run-Test/Idle back to Run-Test/Idle, TDI LSB first
  task automatic scan(input logic is_ir, input logic [31:0] tdi, input int n,
                      input int pause_at, output logic [31:0] out);
    logic [31:0] shift_in;
    logic        bit_out;
    shift_in = tdi;
    out = '0;
    move(1'b1);
    if (is_ir)
    begin
      move(1'b1);
    end
    move(1'b0);
    move(1'b0);
    for (int k = 0; k < n; k++)
    begin
      step(k == n - 1 || k == pause_at, shift_in[0], bit_out);
      shift_in = shift_in >> 1;
      out = {bit_out, out[31:1]};
      if (k == pause_at)
      begin
        // through Pause-DR and Exit2-DR back into Shift-DR
        move(1'b0);
        move(1'b1);
        move(1'b0);
      end
    end
    out = out >> (32 - n);
    move(1'b1);
    move(1'b0);
    move(1'b0);
    if (is_ir)
    begin
      model_instr = decode_opcode(tdi[`JTAG_IR_LEN-1:0]);
    end
    else if (model_instr == INSTR_USER_DATA)
    begin
      model_user = tdi;
    end
  endtask

  task automatic check_bits(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("[FAIL] time %0t: %s scanned out %h, expected %h", $time, what, got, exp);
    end
  endtask

  // the active instruction shows in what a DR scan returns
  task automatic check_instr(input jtag_instr_e exp);
    logic [31:0] tdi;
    logic [31:0] got;
    logic [31:0] want;
    tdi = $random(seed);
    want = predict_dr(exp, model_user, tdi);
    scan(1'b0, tdi, 32, -1, got);
    if (got !== want)
    begin
      value_errors++;
      $display("[FAIL] time %0t: %s not active, DR scan %h expected %h",
               $time, exp.name(), got, want);
    end
  endtask

  task automatic check_user(input logic [`JTAG_USER_LEN-1:0] exp);
    if (user_data !== exp)
    begin
      value_errors++;
      $display("[FAIL] time %0t: user_data %h, expected %h", $time, user_data, exp);
    end
  endtask

  task automatic load_ir(input logic [`JTAG_IR_LEN-1:0] code);
    logic [31:0] got;
    scan(1'b1, {{PAD{1'b0}}, code}, `JTAG_IR_LEN, -1, got);
    check_bits("IR capture", got, {{PAD{1'b0}}, `JTAG_IR_CAPTURE});
  endtask

  task automatic tms_reset();
    repeat (5) move(1'b1);
    move(1'b0);
    move(1'b0);
    model_instr = INSTR_IDCODE;
  endtask

  // TRST low across one rising edge
  task automatic async_reset_pulse();
    @(negedge TCK);
    pulse_n = 1'b0;
    #0.5;
    if (TDO !== 1'b0)
    begin
      value_errors++;
      $display("[FAIL] time %0t: TDO not cleared by rst_n", $time);
    end
    @(posedge TCK);
    TMS <= 1'b1;
    last_tms = 1'b1;
    @(negedge TCK);
    pulse_n = 1'b1;
    model_state = TEST_LOGIC_RESET;
    model_instr = INSTR_IDCODE;
    model_user = '0;
  endtask

  initial
  begin
    logic [31:0] word;
    logic [31:0] tdi;
    logic [31:0] got;
    logic [31:0] want;
    logic        tdo_bit;
    seed = 32'hb152d67b;
    value_errors = 0;
    tdo_errors = 0;
    TMS = 1'b1;
    TDI = 1'b0;
    pulse_n = 1'b1;
    last_tms = 1'b1;
    model_state = TEST_LOGIC_RESET;
    model_instr = INSTR_IDCODE;
    model_user = '0;
    wait (por_n === 1'b1);
    move(1'b0);
    move(1'b0);
    check_instr(INSTR_IDCODE);
    load_ir(INSTR_BYPASS);
    check_instr(INSTR_BYPASS);
    load_ir(5'b10101);
    check_instr(INSTR_BYPASS);
    load_ir(INSTR_USER_DATA);
    word = $random(seed);
    want = predict_dr(model_instr, model_user, word);
    scan(1'b0, word, 32, -1, got);
    check_bits("user first", got, want);
    check_user(word);
    // second scan reads back the first word, with a pause halfway
    word = $random(seed);
    want = predict_dr(model_instr, model_user, word);
    scan(1'b0, word, 32, 13, got);
    check_bits("user readback", got, want);
    check_user(word);
    // leave the TAP in Shift-IR, then TMS high for five edges
    move(1'b1);
    move(1'b1);
    move(1'b0);
    move(1'b0);
    move(1'b0);
    move(1'b0);
    tms_reset();
    check_user(word);
    check_instr(INSTR_IDCODE);
    // TRST halfway through a user DR scan
    load_ir(INSTR_USER_DATA);
    move(1'b1);
    move(1'b0);
    move(1'b0);
    tdi = $random(seed);
    repeat (10)
    begin
      step(1'b0, tdi[0], tdo_bit);
      tdi = tdi >> 1;
    end
    async_reset_pulse();
    check_user('0);
    move(1'b0);
    move(1'b0);
    check_instr(INSTR_IDCODE);
    $display("errors: %0d value mismatches, %0d TDO faults", value_errors, tdo_errors);
    if (value_errors + tdo_errors == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog sized from the number of scans, with margin
  initial
  begin
    #(SCAN_TIMEOUT * 2 + 100);
    $display("watchdog: the run did not finish in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic TCK,
  output logic rst_n
);

  // 4 ns period
  initial
  begin
    TCK = 1'b0;
    forever #2 TCK = ~TCK;
  end

  // reset held for 8 cycles, released away from the rising edge
  initial
  begin
    rst_n = 1'b0;
    repeat (8) @(posedge TCK);
    @(negedge TCK);
    rst_n = 1'b1;
  end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/jtag_pkg.sv
verilog/tap_controller.sv
verilog/instruction_register.sv
verilog/scan_path.sv
verilog/jtag_tap_top.sv
dv/tb_clock_gen.sv
dv/jtag_tap_tb.sv

// ==== verilog/instruction_register.sv ====
`timescale 1ns/1ps
`include "jtag_config.svh"

module instruction_register (
  input  logic                  TCK,
  input  logic                  rst_n,
  input  logic                  TDI,
  input  jtag_pkg::tap_ctrl_t   ctrl,
  output jtag_pkg::jtag_instr_e instr,
  output logic                  ir_tdo
);
  import jtag_pkg::*;

  logic [`JTAG_IR_LEN-1:0] ir_shift;
  logic [`JTAG_IR_LEN-1:0] ir_shadow;

  // shift stage, TDI in at the MSB
  always_ff @(posedge TCK)
  begin
    if (ctrl.capture_ir)
    begin
      ir_shift <= `JTAG_IR_CAPTURE;
    end
    else if (ctrl.shift_ir)
    begin
      ir_shift <= {TDI, ir_shift[`JTAG_IR_LEN-1:1]};
    end
  end

  assign ir_tdo = ir_shift[0];

  // update shadow holds the active instruction
  always_ff @(posedge TCK or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ir_shadow <= INSTR_IDCODE;
    end
    else if (ctrl.test_logic_reset)
    begin
      ir_shadow <= INSTR_IDCODE;
    end
    else if (ctrl.update_ir)
    begin
      ir_shadow <= ir_shift;
    end
  end

  // unknown opcodes fall back to bypass
  always_comb
  begin
    case (ir_shadow)
      INSTR_IDCODE:    instr = INSTR_IDCODE;
      INSTR_USER_DATA: instr = INSTR_USER_DATA;
      default:         instr = INSTR_BYPASS;
    endcase
  end

  a_instr_legal: assert property (
    @(posedge TCK) disable iff (!rst_n)
    instr inside {INSTR_IDCODE, INSTR_USER_DATA, INSTR_BYPASS}
  ) else $error("instruction_register: illegal instruction %b", instr);

endmodule

// ==== verilog/jtag_config.svh ====
`ifndef JTAG_CONFIG_SVH
`define JTAG_CONFIG_SVH

// instruction register width
`define JTAG_IR_LEN 5

// fixed pattern loaded in Capture-IR
// the two LSBs must read 01
`define JTAG_IR_CAPTURE 5'b00101

// device identifier
// version, part number, manufacturer, then the mandatory 1 in bit 0
`define JTAG_IDCODE 32'h4A3C_1093

// width of the user data register and its parallel port
`define JTAG_USER_LEN 32

`endif

// ==== verilog/jtag_pkg.sv ====
`include "jtag_config.svh"

package jtag_pkg;

  // TAP states in the usual 4-bit encoding
  typedef enum logic [3:0] {
    TEST_LOGIC_RESET = 4'h0,
    RUN_TEST_IDLE    = 4'h1,
    SELECT_DR_SCAN   = 4'h2,
    CAPTURE_DR       = 4'h3,
    SHIFT_DR         = 4'h4,
    EXIT1_DR         = 4'h5,
    PAUSE_DR         = 4'h6,
    EXIT2_DR         = 4'h7,
    UPDATE_DR        = 4'h8,
    SELECT_IR_SCAN   = 4'h9,
    CAPTURE_IR       = 4'hA,
    SHIFT_IR         = 4'hB,
    EXIT1_IR         = 4'hC,
    PAUSE_IR         = 4'hD,
    EXIT2_IR         = 4'hE,
    UPDATE_IR        = 4'hF
  } tap_state_e;

  // decoded instructions
  // any code not listed here acts as bypass
  typedef enum logic [`JTAG_IR_LEN-1:0] {
    INSTR_IDCODE    = 5'b00001,
    INSTR_USER_DATA = 5'b00010,
    INSTR_BYPASS    = 5'b11111
  } jtag_instr_e;

  // one flag per TAP state that the registers act on
  typedef struct packed {
    logic test_logic_reset;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic capture_ir;
    logic shift_ir;
    logic update_ir;
  } tap_ctrl_t;

endpackage

// ==== verilog/jtag_tap_top.sv ====
`timescale 1ns/1ps
`include "jtag_config.svh"

module jtag_tap_top (
  input  logic                      TCK,
  input  logic                      rst_n,
  input  logic                      TMS,
  input  logic                      TDI,
  output logic                      TDO,
  output logic [`JTAG_USER_LEN-1:0] user_data
);
  import jtag_pkg::*;

  tap_ctrl_t   ctrl;
  jtag_instr_e instr;
  logic        ir_tdo;

  tap_controller u_tap_controller (
    .TCK   (TCK),
    .rst_n (rst_n),
    .TMS   (TMS),
    .ctrl  (ctrl)
  );

  instruction_register u_instruction_register (
    .TCK    (TCK),
    .rst_n  (rst_n),
    .TDI    (TDI),
    .ctrl   (ctrl),
    .instr  (instr),
    .ir_tdo (ir_tdo)
  );

  // data registers and TDO mux
  scan_path u_scan_path (
    .TCK       (TCK),
    .rst_n     (rst_n),
    .TDI       (TDI),
    .ctrl      (ctrl),
    .instr     (instr),
    .ir_tdo    (ir_tdo),
    .TDO       (TDO),
    .user_data (user_data)
  );

endmodule

// ==== verilog/scan_path.sv ====
`timescale 1ns/1ps
`include "jtag_config.svh"

module scan_path (
  input  logic                      TCK,
  input  logic                      rst_n,
  input  logic                      TDI,
  input  jtag_pkg::tap_ctrl_t       ctrl,
  input  jtag_pkg::jtag_instr_e     instr,
  input  logic                      ir_tdo,
  output logic                      TDO,
  output logic [`JTAG_USER_LEN-1:0] user_data
);
  import jtag_pkg::*;

  logic                      sel_bypass;
  logic                      sel_idcode;
  logic                      sel_user;
  logic                      bypass_reg;
  logic [31:0]               idcode_shift;
  logic [`JTAG_USER_LEN-1:0] user_shift;
  logic                      dr_tdo;

  // exactly one data register is selected
  always_comb
  begin
    sel_bypass = 1'b0;
    sel_idcode = 1'b0;
    sel_user   = 1'b0;
    case (instr)
      INSTR_IDCODE:    sel_idcode = 1'b1;
      INSTR_USER_DATA: sel_user   = 1'b1;
      default:         sel_bypass = 1'b1;
    endcase
  end

  // bypass is a single stage that captures 0
  always_ff @(posedge TCK)
  begin
    if (sel_bypass && ctrl.capture_dr)
    begin
      bypass_reg <= 1'b0;
    end
    else if (sel_bypass && ctrl.shift_dr)
    begin
      bypass_reg <= TDI;
    end
  end

  always_ff @(posedge TCK)
  begin
    if (sel_idcode && ctrl.capture_dr)
    begin
      idcode_shift <= `JTAG_IDCODE;
    end
    else if (sel_idcode && ctrl.shift_dr)
    begin
      idcode_shift <= {TDI, idcode_shift[31:1]};
    end
  end

  // user stage reads back the current parallel value
  always_ff @(posedge TCK)
  begin
    if (sel_user && ctrl.capture_dr)
    begin
      user_shift <= user_data;
    end
    else if (sel_user && ctrl.shift_dr)
    begin
      user_shift <= {TDI, user_shift[`JTAG_USER_LEN-1:1]};
    end
  end

  always_ff @(posedge TCK or negedge rst_n)
  begin
    if (!rst_n)
    begin
      user_data <= '0;
    end
    else if (sel_user && ctrl.update_dr)
    begin
      user_data <= user_shift;
    end
  end

  // LSB of the selected data register
  always_comb
  begin
    case (1'b1)
      sel_idcode: dr_tdo = idcode_shift[0];
      sel_user:   dr_tdo = user_shift[0];
      default:    dr_tdo = bypass_reg;
    endcase
  end

  // TDO only drives during the two shift states
  assign TDO = (ctrl.shift_ir & ir_tdo) | (ctrl.shift_dr & dr_tdo);

  a_tdo_quiet: assert property (
    @(posedge TCK) disable iff (!rst_n)
    !(ctrl.shift_ir || ctrl.shift_dr) |-> !TDO
  ) else $error("scan_path: TDO active outside shift states");

endmodule

// ==== verilog/tap_controller.sv ====
`timescale 1ns/1ps

module tap_controller (
  input  logic                TCK,
  input  logic                rst_n,
  input  logic                TMS,
  output jtag_pkg::tap_ctrl_t ctrl
);
  import jtag_pkg::*;

  tap_state_e state;
  tap_state_e next_state;

  // state register, TRST forces Test-Logic-Reset
  always_ff @(posedge TCK or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= TEST_LOGIC_RESET;
    end
    else
    begin
      state <= next_state;
    end
  end

  // standard next-state table, TMS picks the branch
  always_comb
  begin
    case (state)
      TEST_LOGIC_RESET: next_state = TMS ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
      RUN_TEST_IDLE:    next_state = TMS ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      SELECT_DR_SCAN:   next_state = TMS ? SELECT_IR_SCAN   : CAPTURE_DR;
      CAPTURE_DR:       next_state = TMS ? EXIT1_DR         : SHIFT_DR;
      SHIFT_DR:         next_state = TMS ? EXIT1_DR         : SHIFT_DR;
      EXIT1_DR:         next_state = TMS ? UPDATE_DR        : PAUSE_DR;
      PAUSE_DR:         next_state = TMS ? EXIT2_DR         : PAUSE_DR;
      EXIT2_DR:         next_state = TMS ? UPDATE_DR        : SHIFT_DR;
      UPDATE_DR:        next_state = TMS ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      SELECT_IR_SCAN:   next_state = TMS ? TEST_LOGIC_RESET : CAPTURE_IR;
      CAPTURE_IR:       next_state = TMS ? EXIT1_IR         : SHIFT_IR;
      SHIFT_IR:         next_state = TMS ? EXIT1_IR         : SHIFT_IR;
      EXIT1_IR:         next_state = TMS ? UPDATE_IR        : PAUSE_IR;
      PAUSE_IR:         next_state = TMS ? EXIT2_IR         : PAUSE_IR;
      EXIT2_IR:         next_state = TMS ? UPDATE_IR        : SHIFT_IR;
      UPDATE_IR:        next_state = TMS ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      default:          next_state = TEST_LOGIC_RESET;
    endcase
  end

  // flags follow the registered state with no extra delay
  always_comb
  begin
    ctrl.test_logic_reset = (state == TEST_LOGIC_RESET);
    ctrl.capture_dr       = (state == CAPTURE_DR);
    ctrl.shift_dr         = (state == SHIFT_DR);
    ctrl.update_dr        = (state == UPDATE_DR);
    ctrl.capture_ir       = (state == CAPTURE_IR);
    ctrl.shift_ir         = (state == SHIFT_IR);
    ctrl.update_ir        = (state == UPDATE_IR);
  end

  // the registers downstream rely on never seeing two strobes at once
  a_ctrl_onehot: assert property (
    @(posedge TCK) disable iff (!rst_n)
    $onehot0(ctrl)
  ) else $error("tap_controller: more than one ctrl flag high");

  // five edges with TMS high reach Test-Logic-Reset from anywhere
  a_tms_reset: assert property (
    @(posedge TCK) disable iff (!rst_n)
    (TMS && $past(TMS) && $past(TMS, 2) && $past(TMS, 3) && $past(TMS, 4))
      |=> (state == TEST_LOGIC_RESET)
  ) else $error("tap_controller: TMS high for five cycles missed reset");

endmodule
